/* verilog/serial_bus_defs.svh */
// widths, memory size and start code shared by the slave and its bench
// SB_ADDR_WIDTH must be wide enough to index SB_ADDR_DEPTH words
// the frame is 3 + SB_ID_WIDTH + 2 + SB_ADDR_WIDTH bits long
`ifndef SERIAL_BUS_DEFS_SVH
`define SERIAL_BUS_DEFS_SVH

// bits per memory word, sent msb first
`define SB_DATA_WIDTH 32

// memory size in words and the address bits that index it
`define SB_ADDR_DEPTH 256
`define SB_ADDR_WIDTH 8

// slave id field of the frame
`define SB_ID_WIDTH 2

// pattern that opens every configuration frame
`define SB_START_CODE 3'b111

`endif

/* verilog/serial_bus_pkg.sv */
// types of the serial bus slave
// field widths follow the defines header, the frame layout is fixed here
`include "serial_bus_defs.svh"

package serial_bus_pkg;

    // one memory word
    typedef logic [`SB_DATA_WIDTH-1:0] word_t;

    // one memory address
    typedef logic [`SB_ADDR_WIDTH-1:0] addr_t;

    // configuration frame, first bit on the wire is start[2]
    typedef struct packed {
        logic [2:0]               start;
        logic [`SB_ID_WIDTH-1:0]  slave_id;
        // high for a write
        logic                     is_write;
        logic                     burst;
        addr_t                    addr;
    } cfg_frame_t;

endpackage

/* verilog/mem_if.sv */
// port between the transaction controller and the word memory
// rdata is valid in the cycle after re, we and re are never high together
`timescale 1ns/10ps
`include "serial_bus_defs.svh"

interface mem_if (
    input logic clk
);
    logic                      we;
    logic                      re;
    logic [`SB_ADDR_WIDTH-1:0] addr;
    logic [`SB_DATA_WIDTH-1:0] wdata;
    logic [`SB_DATA_WIDTH-1:0] rdata;

    modport controller (input clk, output we, output re, output addr, output wdata, input rdata);

    modport memory (input clk, input we, input re, input addr, input wdata, output rdata);

endinterface

/* verilog/serial_shift_in.sv */
// collects bit_in msb first on every cycle with shift_en high
// done pulses one cycle after the last bit of a payload
// payload holds until the next shift, so it is stable while done is high
`timescale 1ns/10ps

module serial_shift_in
    import serial_bus_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     bit_in,
    input  logic     shift_en,
    output payload_t payload,
    output logic     done
);
    localparam int W  = $bits(payload_t);
    localparam int CW = $clog2(W);
    localparam logic [CW-1:0] LAST_BIT = CW'(W - 1);

    logic [W-1:0]  shreg;
    logic [CW-1:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {shreg[W-2:0], bit_in};
        end
    end

    // bit counter wraps to zero on a full payload
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (shift_en) begin
                if (bit_cnt == LAST_BIT) begin
                    bit_cnt <= '0;
                    done    <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    assign payload = payload_t'(shreg);

    // a payload takes W accepted bits, so two done pulses are never adjacent
    assert property (@(posedge clk) disable iff (!rstN) done |=> !done);

endmodule

/* verilog/word_serializer.sv */
// drives a loaded word onto rd msb first, one bit per advance
// first bit is on rd the cycle after load, load and advance never coincide
// empty is combinational and marks the cycle the final bit is taken
`timescale 1ns/10ps

module word_serializer
    import serial_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  load,
    input  word_t word,
    input  logic  advance,
    output logic  rd,
    output logic  empty
);
    localparam int W  = $bits(word_t);
    localparam int CW = $clog2(W);
    localparam logic [CW-1:0] LAST_BIT = CW'(W - 1);

    word_t         shreg;
    logic [CW-1:0] bit_cnt;

    // shreg is cleared so rd is low out of reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shreg   <= '0;
            bit_cnt <= '0;
        end else if (load) begin
            shreg   <= word;
            bit_cnt <= '0;
        end else if (advance) begin
            shreg   <= {shreg[W-2:0], 1'b0};
            // wraps after the last bit, ready for the next load
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign rd = shreg[W-1];

    // also pulses on write beats, the controller only looks at it when reading
    assign empty = advance && (bit_cnt == LAST_BIT);

endmodule

/* verilog/slave_ram.sv */
// word memory, synchronous write and registered read
// contents are not reset and come up unknown
// a write and a read to one address in one cycle return the old word
`timescale 1ns/10ps
`include "serial_bus_defs.svh"

module slave_ram
    import serial_bus_pkg::*;
(
    input logic   clk,
    mem_if.memory mem
);
    word_t ram [`SB_ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // rdata follows re by one cycle
    always_ff @(posedge clk) begin
        if (mem.re) begin
            mem.rdata <= ram[mem.addr];
        end
    end

    // burst addresses from the controller must stay inside the array
    assert property (@(posedge clk) (mem.we || mem.re) |-> (int'(mem.addr) < `SB_ADDR_DEPTH));

endmodule

/* verilog/slave_ctrl.sv */
// transaction FSM of the serial slave, frame check, write, read and burst
// frames with a wrong start code or id are dropped, ready stays low
// a single transfer ends after one word, a burst ends on last
// between burst read words ready is low for two cycles
`timescale 1ns/10ps
`include "serial_bus_defs.svh"

module slave_ctrl
    import serial_bus_pkg::*;
#(
    parameter int SLAVE_ID = 1
) (
    input  logic         clk,
    input  logic         rstN,
    input  logic         control,
    input  logic         valid,
    input  logic         last,
    input  cfg_frame_t   frame,
    input  logic         frame_done,
    input  word_t        wr_word,
    input  logic         wr_done,
    output logic         frame_shift,
    output logic         data_shift,
    output logic         ready,
    output logic         ser_load,
    input  logic         ser_empty,
    mem_if.controller    mem
);
    localparam logic [`SB_ID_WIDTH-1:0] MY_ID = SLAVE_ID[`SB_ID_WIDTH-1:0];

    typedef enum logic [2:0] {
        S_IDLE,
        S_CONFIG,
        S_DECODE,
        S_WRITE,
        S_READ_FETCH,
        S_READ_SEND
    } state_t;

    state_t state;
    addr_t  addr_q;
    logic   burst_q;
    logic   last_seen;
    logic   rd_pending;
    logic   frame_ok;

    assign frame_ok = (frame.start == `SB_START_CODE) && (frame.slave_id == MY_ID);

    // first frame bit is taken in idle, the rest until the frame is complete
    assign frame_shift = ((state == S_IDLE) && control) || ((state == S_CONFIG) && !frame_done);

    // a single write drops ready as soon as its word is in
    assign ready = (state == S_READ_SEND) ||
                   ((state == S_WRITE) && !last_seen && !(wr_done && !burst_q));

    // one accepted beat, feeds both the write shifter and the read serializer
    assign data_shift = valid && ready;

    assign ser_load  = (state == S_READ_FETCH) && rd_pending;
    assign mem.we    = (state == S_WRITE) && wr_done;
    assign mem.re    = ((state == S_DECODE) && frame_ok && !frame.is_write) ||
                       ((state == S_READ_FETCH) && !rd_pending);
    assign mem.addr  = (state == S_DECODE) ? frame.addr : addr_q;
    assign mem.wdata = wr_word;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= S_IDLE;
            addr_q     <= '0;
            burst_q    <= 1'b0;
            last_seen  <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= mem.re;
            case (state)
                S_IDLE: begin
                    if (control) begin
                        state <= S_CONFIG;
                    end
                end
                S_CONFIG: begin
                    if (frame_done) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    addr_q    <= frame.addr;
                    burst_q   <= frame.burst;
                    last_seen <= 1'b0;
                    if (!frame_ok) begin
                        state <= S_IDLE;
                    end else if (frame.is_write) begin
                        state <= S_WRITE;
                    end else begin
                        state <= S_READ_FETCH;
                    end
                end
                S_WRITE: begin
                    // last comes with the final bit, the word lands a cycle later
                    if (data_shift && last && burst_q) begin
                        last_seen <= 1'b1;
                    end
                    if (wr_done) begin
                        if (!burst_q || last_seen) begin
                            state <= S_IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                S_READ_FETCH: begin
                    if (rd_pending) begin
                        state <= S_READ_SEND;
                    end
                end
                S_READ_SEND: begin
                    if (ser_empty) begin
                        if (burst_q && !last) begin
                            addr_q <= addr_q + 1'b1;
                            state  <= S_READ_FETCH;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // the memory port never sees a write and a read in the same cycle
    assert property (@(posedge clk) disable iff (!rstN) !(mem.we && mem.re));

    // no handshake is offered until a frame has been accepted
    assert property (@(posedge clk) disable iff (!rstN) (state == S_IDLE) |-> !ready);

endmodule

/* verilog/serial_slave_top.sv */
// serial bus slave with a word memory
// frame on control msb first, then data on wd or rd under valid and ready
// SLAVE_ID must fit in SB_ID_WIDTH bits
// memory is not reset, reads of unwritten words return unknown data
`timescale 1ns/10ps

module serial_slave_top
    import serial_bus_pkg::*;
#(
    parameter int SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wd,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready
);
    cfg_frame_t frame;
    word_t      wr_word;
    logic       frame_done;
    logic       wr_done;
    logic       frame_shift;
    logic       data_shift;
    logic       ser_load;
    logic       ser_empty;

    mem_if mem_bus (.clk(clk));

    serial_shift_in #(.payload_t(cfg_frame_t)) frame_rx (
        .clk      (clk),
        .rstN     (rstN),
        .bit_in   (control),
        .shift_en (frame_shift),
        .payload  (frame),
        .done     (frame_done)
    );

    // every transfer is whole words, so both bit counters stay aligned
    // even though each sees the other phase's beats
    serial_shift_in #(.payload_t(word_t)) data_rx (
        .clk      (clk),
        .rstN     (rstN),
        .bit_in   (wd),
        .shift_en (data_shift),
        .payload  (wr_word),
        .done     (wr_done)
    );

    slave_ctrl #(.SLAVE_ID(SLAVE_ID)) ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .control     (control),
        .valid       (valid),
        .last        (last),
        .frame       (frame),
        .frame_done  (frame_done),
        .wr_word     (wr_word),
        .wr_done     (wr_done),
        .frame_shift (frame_shift),
        .data_shift  (data_shift),
        .ready       (ready),
        .ser_load    (ser_load),
        .ser_empty   (ser_empty),
        .mem         (mem_bus.controller)
    );

    word_serializer ser (
        .clk     (clk),
        .rstN    (rstN),
        .load    (ser_load),
        .word    (mem_bus.rdata),
        .advance (data_shift),
        .rd      (rd),
        .empty   (ser_empty)
    );

    slave_ram ram (
        .clk (clk),
        .mem (mem_bus.memory)
    );

endmodule

/* bench/slave_checker.sv */
// watches the slave ports and keeps a model of the word memory
// reads of words the model never saw written are reported as mismatches
// a test is closed when test_idx changes
`timescale 1ns/10ps
`include "serial_bus_defs.svh"

module slave_checker
    import serial_bus_pkg::*;
#(
    parameter int SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wd,
    input  logic valid,
    input  logic last,
    input  logic rd,
    input  logic ready,
    input  int   test_idx,
    output int   pass_count,
    output int   fail_count
);
    localparam int FW = $bits(cfg_frame_t);
    localparam logic [`SB_ID_WIDTH-1:0] MY_ID = SLAVE_ID[`SB_ID_WIDTH-1:0];

    typedef enum logic [1:0] {
        P_IDLE,
        P_FRAME,
        P_XFER
    } phase_t;

    word_t         model [`SB_ADDR_DEPTH];
    phase_t        phase;
    logic [FW-1:0] frame_bits;
    int            frame_cnt;
    cfg_frame_t    cur;
    addr_t         addr;
    word_t         word_acc;
    int            bit_cnt;
    int            words_done;
    int            test_errs;
    int            prev_idx;

    task automatic close_test(input int idx);
        if (phase != P_IDLE) begin
            $display("test %0d ended before its transfer was complete, %0d words seen",
                     idx, words_done);
            test_errs++;
        end
        if (test_errs == 0) begin
            pass_count++;
            $display("test %0d passed, %0d words", idx, words_done);
        end else begin
            fail_count++;
            $display("test %0d failed with %0d errors", idx, test_errs);
        end
        phase      = P_IDLE;
        test_errs  = 0;
        words_done = 0;
    endtask

    task automatic decode_frame();
        cur = cfg_frame_t'(frame_bits);
        if ((cur.start == `SB_START_CODE) && (cur.slave_id == MY_ID)) begin
            addr     = cur.addr;
            bit_cnt  = 0;
            word_acc = '0;
            phase    = P_XFER;
        end else begin
            // frame for another slave or a bad start code
            phase = P_IDLE;
        end
    endtask

    task automatic take_beat();
        word_acc = {word_acc[`SB_DATA_WIDTH-2:0], cur.is_write ? wd : rd};
        bit_cnt++;
        if (bit_cnt == `SB_DATA_WIDTH) begin
            if (cur.is_write) begin
                model[addr] = word_acc;
            end else if (word_acc !== model[addr]) begin
                $display("[ERROR] test %0d rd_word at 0x%h expected 0x%h got 0x%h",
                         test_idx, addr, model[addr], word_acc);
                test_errs++;
            end
            words_done++;
            addr    = addr + 1'b1;
            bit_cnt = 0;
            if (!cur.burst || last) begin
                phase = P_IDLE;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            phase      = P_IDLE;
            frame_cnt  = 0;
            bit_cnt    = 0;
            words_done = 0;
            test_errs  = 0;
            prev_idx   = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (test_idx != prev_idx) begin
                close_test(prev_idx);
                prev_idx = test_idx;
            end
            // outside an accepted transfer the slave offers no handshake
            if (ready && (phase != P_XFER)) begin
                $display("[ERROR] test %0d ready expected 0x0 got 0x1", test_idx);
                test_errs++;
            end
            case (phase)
                P_IDLE: begin
                    if (control) begin
                        frame_bits = {{(FW-1){1'b0}}, control};
                        frame_cnt  = 1;
                        phase      = P_FRAME;
                    end
                end
                P_FRAME: begin
                    frame_bits = {frame_bits[FW-2:0], control};
                    frame_cnt++;
                    if (frame_cnt == FW) begin
                        decode_frame();
                    end
                end
                default: begin
                    if (valid && ready) begin
                        take_beat();
                    end
                end
            endcase
        end
    end

endmodule

/* bench/tb_serial_slave.sv */
// testbench of the serial slave that runs the rows of the table in order
// inputs change on the falling edge
// ready only moves on the rising edge and is read on the falling edge
// write data and valid gaps come from a Galois LFSR
`timescale 1ns/10ps
`include "serial_bus_defs.svh"

module tb_serial_slave
    import serial_bus_pkg::*;
;
    localparam int DUT_ID   = 1;
    localparam int NUM_ROWS = 9;

    typedef struct packed {
        logic                    is_write;
        logic [`SB_ID_WIDTH-1:0] id;
        logic                    burst;
        addr_t                   addr;
        logic [7:0]              words;
        logic                    gaps;
    } row_t;

    logic        clk;
    logic        rstN;
    logic        control;
    logic        wd;
    logic        valid;
    logic        last;
    logic        rd;
    logic        ready;
    int          test_idx;
    int          pass_count;
    int          fail_count;
    logic [31:0] lfsr_state;
    row_t        rows [NUM_ROWS];

    serial_slave_top #(.SLAVE_ID(DUT_ID)) uut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wd      (wd),
        .valid   (valid),
        .last    (last),
        .rd      (rd),
        .ready   (ready)
    );

    slave_checker #(.SLAVE_ID(DUT_ID)) chk (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .wd         (wd),
        .valid      (valid),
        .last       (last),
        .rd         (rd),
        .ready      (ready),
        .test_idx   (test_idx),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    always #4 clk = ~clk;

    // taps of x^32 + x^22 + x^2 + x + 1 for a right shift
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int i = 0; i < `SB_DATA_WIDTH; i++) begin
            w = {w[`SB_DATA_WIDTH-2:0], random_bit()};
        end
        return w;
    endfunction

    function automatic int timeout_cycles();
        int total;
        total = 200;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += 15 + int'(rows[i].words) * `SB_DATA_WIDTH * 4 + 60;
        end
        return total;
    endfunction

    task automatic send_frame(input row_t r);
        cfg_frame_t f;
        f = '{start: `SB_START_CODE, slave_id: r.id, is_write: r.is_write,
              burst: r.burst, addr: r.addr};
        for (int i = $bits(cfg_frame_t) - 1; i >= 0; i--) begin
            @(negedge clk);
            control = f[i];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    // holds one beat until the slave takes it
    task automatic send_beat(input logic bit_val, input logic is_last, input logic use_gaps);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            valid    = use_gaps ? !random_bit() : 1'b1;
            wd       = bit_val;
            last     = is_last;
            accepted = valid && ready;
        end
    endtask

    task automatic wait_ready_low(input int cycles);
        int low_cnt;
        low_cnt = 0;
        while (low_cnt < cycles) begin
            @(negedge clk);
            low_cnt = ready ? 0 : low_cnt + 1;
        end
    endtask

    task automatic run_row(input row_t r);
        word_t w;
        logic  is_last;
        send_frame(r);
        if (int'(r.id) != DUT_ID) begin
            // a whole word is offered anyway and must not reach the memory
            w = random_word();
            for (int b = `SB_DATA_WIDTH - 1; b >= 0; b--) begin
                @(negedge clk);
                valid = 1'b1;
                wd    = w[b];
            end
        end else begin
            for (int n = 0; n < int'(r.words); n++) begin
                w = r.is_write ? random_word() : '0;
                for (int b = `SB_DATA_WIDTH - 1; b >= 0; b--) begin
                    is_last = r.burst && (n == int'(r.words) - 1) && (b == 0);
                    send_beat(w[b], is_last, r.gaps);
                end
            end
        end
        @(negedge clk);
        valid = 1'b0;
        last  = 1'b0;
        wd    = 1'b0;
        wait_ready_low(4);
    endtask

    initial begin
        int cycle_count;
        int limit;
        cycle_count = 0;
        @(posedge rstN);
        limit = timeout_cycles();
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        control    = 1'b0;
        wd         = 1'b0;
        valid      = 1'b0;
        last       = 1'b0;
        test_idx   = 0;
        lfsr_state = 32'h9be1;
        //        write  id    burst addr   words gaps
        rows[0] = '{1'b1, 2'd1, 1'b0, 8'h10, 8'd1, 1'b0};
        rows[1] = '{1'b0, 2'd1, 1'b0, 8'h10, 8'd1, 1'b0};
        rows[2] = '{1'b1, 2'd1, 1'b1, 8'h20, 8'd4, 1'b0};
        rows[3] = '{1'b0, 2'd1, 1'b1, 8'h20, 8'd4, 1'b0};
        // a wrong id must leave the word at 0x10 alone
        rows[4] = '{1'b1, 2'd2, 1'b0, 8'h10, 8'd1, 1'b0};
        rows[5] = '{1'b0, 2'd1, 1'b0, 8'h10, 8'd1, 1'b0};
        rows[6] = '{1'b0, 2'd1, 1'b1, 8'h20, 8'd4, 1'b1};
        rows[7] = '{1'b1, 2'd1, 1'b0, 8'h30, 8'd1, 1'b1};
        rows[8] = '{1'b0, 2'd1, 1'b0, 8'h30, 8'd1, 1'b1};

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        repeat (4) @(negedge clk);

        for (int i = 0; i < NUM_ROWS; i++) begin
            test_idx = i;
            run_row(rows[i]);
        end
        test_idx = NUM_ROWS;
        repeat (3) @(negedge clk);

        $display("tests run %0d, passed %0d, failed %0d", NUM_ROWS, pass_count, fail_count);
        if ((fail_count == 0) && (pass_count == NUM_ROWS)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
verilog/serial_bus_pkg.sv
verilog/mem_if.sv
verilog/serial_shift_in.sv
verilog/word_serializer.sv
verilog/slave_ram.sv
verilog/slave_ctrl.sv
verilog/serial_slave_top.sv
bench/slave_checker.sv
bench/tb_serial_slave.sv

/* run_sim.sh */
#!/bin/sh
# builds the serial slave testbench with Verilator, runs it and checks the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_serial_slave -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
